/* uart_console_pkg.sv */
// Shared widths, UART register map and console constants, referenced by scoped name everywhere
package uart_console_pkg;

	// --------------------------------------------------
	// Bus and character widths
	// --------------------------------------------------

	// Byte address on the AXI4-Lite port
	typedef logic [31:0] axi_addr_t;
	// Full data word on the AXI4-Lite port
	typedef logic [31:0] axi_data_t;
	// One serial character
	typedef logic [7:0] uart_byte_t;
	// LED bank on the board
	typedef logic [7:0] led_t;

	// OKAY code on BRESP and RRESP
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// --------------------------------------------------
	// Hard UART register map
	// --------------------------------------------------

	// UART0 base in the HPS address map
	localparam axi_addr_t UART_BASE_ADDR = 32'hFFC0_2000;
	// RBR on read, THR on write
	localparam axi_addr_t UART_RBR_THR_OFFSET = 32'h0000_0000;
	// Line status register
	localparam axi_addr_t UART_LSR_OFFSET = 32'h0000_0014;

	// LSR bit positions
	localparam int LSR_DR_BIT = 0;
	localparam int LSR_THRE_BIT = 5;

	// --------------------------------------------------
	// Console behaviour
	// --------------------------------------------------

	// Greeting, first character in the top byte
	localparam int HELLO_MSG_LEN = 26;
	localparam logic [8*HELLO_MSG_LEN-1:0] HELLO_MSG = "Hello from the FPGA side\r\n";

	// ASCII '0', start of the LED digit range
	localparam uart_byte_t DIGIT_BASE = 8'h30;

	// Short periods so a simulation run stays small
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int POLL_CYCLES = 64;

endpackage

/* uart_reg_if.sv */
// Single register access channel from the console controller to the AXI4-Lite master
interface uart_reg_if;

	// Access request, held with its payload until done
	logic req;
	// High for a write, low for a read
	logic write;
	// Full byte address of the UART register
	uart_console_pkg::axi_addr_t addr;
	// Character for a write, only the low byte reaches the bus
	uart_console_pkg::uart_byte_t wdata;

	// One cycle pulse when the access has finished
	logic done;
	// Read data, valid while done is high
	uart_console_pkg::axi_data_t rdata;

	// Controller side issues the access
	modport ctrl (
		output req,
		output write,
		output addr,
		output wdata,
		input  done,
		input  rdata
	);

	// Master side runs it on AXI4-Lite
	modport master (
		input  req,
		input  write,
		input  addr,
		input  wdata,
		output done,
		output rdata
	);

endinterface

/* key_debounce.sv */
// Push button conditioner, turns the raw active-low key into a clean pressed level
module key_debounce (
	input  logic pll_0_clock,
	input  logic master_reset,
	input  logic key_n,
	output logic pressed
);

	// Counter wide enough for the debounce window
	typedef logic [$clog2(uart_console_pkg::DEBOUNCE_CYCLES)-1:0] db_cnt_t;

	// Two flops against metastability
	logic [1:0] key_sync;
	// Cycles the new level has held so far
	db_cnt_t stable_cnt;
	// Synchronized key, active high
	logic key_level;

	assign key_level = ~key_sync[1];

	// --------------------------------------------------
	// Synchronizer
	// --------------------------------------------------

	always_ff @(posedge pll_0_clock or posedge master_reset) begin
		if (master_reset) begin
			// Released key reads high
			key_sync <= 2'b11;
		end else begin
			key_sync <= {key_sync[0], key_n};
		end
	end

	// --------------------------------------------------
	// Stability counter
	// --------------------------------------------------

	always_ff @(posedge pll_0_clock or posedge master_reset) begin
		if (master_reset) begin
			stable_cnt <= '0;
			pressed <= 1'b0;
		end else if (key_level == pressed) begin
			// No change pending, restart the window
			stable_cnt <= '0;
		end else if (stable_cnt == db_cnt_t'(uart_console_pkg::DEBOUNCE_CYCLES - 1)) begin
			// Held long enough, accept the new level
			stable_cnt <= '0;
			pressed <= key_level;
		end else begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

endmodule

/* axi_lite_master.sv */
// AXI4-Lite master, runs one controller register access at a time as a write or read transaction
module axi_lite_master (
	input  logic                         pll_0_clock,
	input  logic                         master_reset,
	uart_reg_if.master                   reg_bus,
	output uart_console_pkg::axi_addr_t  awaddr,
	output logic [2:0]                   awprot,
	output logic                         awvalid,
	input  logic                         awready,
	output uart_console_pkg::axi_data_t  wdata,
	output logic [3:0]                   wstrb,
	output logic                         wvalid,
	input  logic                         wready,
	input  logic [1:0]                   bresp,
	input  logic                         bvalid,
	output logic                         bready,
	output uart_console_pkg::axi_addr_t  araddr,
	output logic [2:0]                   arprot,
	output logic                         arvalid,
	input  logic                         arready,
	input  uart_console_pkg::axi_data_t  rdata,
	input  logic [1:0]                   rresp,
	input  logic                         rvalid,
	output logic                         rready
);

	typedef enum logic [2:0] {
		M_IDLE,
		M_WR_ADDR_DATA,
		M_WR_RESP,
		M_RD_ADDR,
		M_RD_DATA
	} mst_state_t;

	mst_state_t state;
	// Address of the access in flight, shared by AW and AR
	uart_console_pkg::axi_addr_t addr_q;
	// AW or W has finished its handshake, now or earlier
	logic aw_accepted;
	logic w_accepted;
	// New access, ignoring the req still high during done
	logic start;

	assign start = reg_bus.req && !reg_bus.done;
	assign aw_accepted = !awvalid || awready;
	assign w_accepted = !wvalid || wready;

	assign awaddr = addr_q;
	assign araddr = addr_q;
	// Unprivileged, secure, data access
	assign awprot = 3'b000;
	assign arprot = 3'b000;
	// Byte registers, only lane 0 is written
	assign wstrb = 4'b0001;

	// --------------------------------------------------
	// Transaction FSM
	// --------------------------------------------------

	always_ff @(posedge pll_0_clock or posedge master_reset) begin
		if (master_reset) begin
			state <= M_IDLE;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
			reg_bus.done <= 1'b0;
		end else begin
			reg_bus.done <= 1'b0;
			case (state)
				M_IDLE: begin
					if (start && reg_bus.write) begin
						// AW and W go out together
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						state <= M_WR_ADDR_DATA;
					end else if (start) begin
						arvalid <= 1'b1;
						state <= M_RD_ADDR;
					end
				end
				M_WR_ADDR_DATA: begin
					// Each channel drops on its own ready
					if (awready) awvalid <= 1'b0;
					if (wready) wvalid <= 1'b0;
					if (aw_accepted && w_accepted) begin
						bready <= 1'b1;
						state <= M_WR_RESP;
					end
				end
				M_WR_RESP: begin
					if (bvalid) begin
						bready <= 1'b0;
						reg_bus.done <= 1'b1;
						state <= M_IDLE;
					end
				end
				M_RD_ADDR: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						state <= M_RD_DATA;
					end
				end
				M_RD_DATA: begin
					if (rvalid) begin
						rready <= 1'b0;
						reg_bus.done <= 1'b1;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// Payload, latched at start and on the R handshake
	always_ff @(posedge pll_0_clock) begin
		if (state == M_IDLE && start) begin
			addr_q <= reg_bus.addr;
			wdata <= {24'h00_0000, reg_bus.wdata};
		end
		if (state == M_RD_DATA && rvalid) begin
			reg_bus.rdata <= rdata;
		end
	end

endmodule

/* uart_console_ctrl.sv */
// Console FSM for the greeting, receive polling, LED toggling and echo over register accesses
module uart_console_ctrl (
	input  logic                   pll_0_clock,
	input  logic                   master_reset,
	input  logic                   pressed,
	uart_reg_if.ctrl               reg_bus,
	output uart_console_pkg::led_t led
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_WAIT_RELEASE,
		ST_TX_STATUS,
		ST_TX_DATA,
		ST_RX_STATUS,
		ST_RX_DATA,
		ST_UPDATE_LED,
		ST_ECHO_STATUS,
		ST_ECHO_DATA
	} ctrl_state_t;

	typedef logic [$clog2(uart_console_pkg::HELLO_MSG_LEN)-1:0] msg_idx_t;
	typedef logic [$clog2(uart_console_pkg::POLL_CYCLES)-1:0] poll_cnt_t;

	ctrl_state_t state;
	// Next greeting character
	msg_idx_t msg_idx;
	// Idle cycles since the last poll
	poll_cnt_t poll_cnt;
	// Last received character
	uart_console_pkg::uart_byte_t rx_byte;
	// Distance from '0', wraps high for bytes below it
	uart_console_pkg::uart_byte_t digit_off;
	uart_console_pkg::uart_byte_t hello_byte;
	logic is_status_read;
	logic is_access;
	// LSR flags, meaningful only on a status read done
	logic thre;
	logic dr;

	assign thre = reg_bus.rdata[uart_console_pkg::LSR_THRE_BIT];
	assign dr = reg_bus.rdata[uart_console_pkg::LSR_DR_BIT];

	// First character sits in the top byte of the string
	assign hello_byte = uart_console_pkg::HELLO_MSG[
		8*(uart_console_pkg::HELLO_MSG_LEN - 1 - int'(msg_idx)) +: 8];
	assign digit_off = rx_byte - uart_console_pkg::DIGIT_BASE;

	assign is_status_read = state inside {ST_TX_STATUS, ST_RX_STATUS, ST_ECHO_STATUS};
	assign is_access = is_status_read || (state inside {ST_TX_DATA, ST_RX_DATA, ST_ECHO_DATA});

	// --------------------------------------------------
	// Access payload, fixed by the state
	// --------------------------------------------------

	assign reg_bus.write = (state == ST_TX_DATA) || (state == ST_ECHO_DATA);
	assign reg_bus.addr = uart_console_pkg::UART_BASE_ADDR + (is_status_read ?
		uart_console_pkg::UART_LSR_OFFSET : uart_console_pkg::UART_RBR_THR_OFFSET);
	assign reg_bus.wdata = (state == ST_TX_DATA) ? hello_byte : rx_byte;

	// Request low for one cycle after every done
	always_ff @(posedge pll_0_clock or posedge master_reset) begin
		if (master_reset) begin
			reg_bus.req <= 1'b0;
		end else begin
			reg_bus.req <= is_access && !reg_bus.done;
		end
	end

	// --------------------------------------------------
	// Main FSM
	// --------------------------------------------------

	always_ff @(posedge pll_0_clock or posedge master_reset) begin
		if (master_reset) begin
			state <= ST_IDLE;
			msg_idx <= '0;
			poll_cnt <= '0;
			led <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Key wins over the poll timer
					if (pressed) begin
						state <= ST_WAIT_RELEASE;
					end else if (poll_cnt == poll_cnt_t'(uart_console_pkg::POLL_CYCLES - 1)) begin
						poll_cnt <= '0;
						state <= ST_RX_STATUS;
					end else begin
						poll_cnt <= poll_cnt + 1'b1;
					end
				end
				ST_WAIT_RELEASE: begin
					if (!pressed) begin
						msg_idx <= '0;
						state <= ST_TX_STATUS;
					end
				end
				// Greeting, LSR until THRE then one THR write
				ST_TX_STATUS: begin
					if (reg_bus.done && thre) state <= ST_TX_DATA;
				end
				ST_TX_DATA: begin
					if (reg_bus.done) begin
						if (msg_idx == msg_idx_t'(uart_console_pkg::HELLO_MSG_LEN - 1)) begin
							state <= ST_IDLE;
						end else begin
							msg_idx <= msg_idx + 1'b1;
							state <= ST_TX_STATUS;
						end
					end
				end
				// Poll, nothing waiting sends us back
				ST_RX_STATUS: begin
					if (reg_bus.done) state <= dr ? ST_RX_DATA : ST_IDLE;
				end
				ST_RX_DATA: begin
					if (reg_bus.done) state <= ST_UPDATE_LED;
				end
				ST_UPDATE_LED: begin
					// Digits '0' to '7' flip their LED
					if (digit_off <= 8'd7) led[digit_off[2:0]] <= ~led[digit_off[2:0]];
					state <= ST_ECHO_STATUS;
				end
				ST_ECHO_STATUS: begin
					if (reg_bus.done && thre) state <= ST_ECHO_DATA;
				end
				ST_ECHO_DATA: begin
					if (reg_bus.done) state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Received character, taken from RBR on done
	always_ff @(posedge pll_0_clock) begin
		if (state == ST_RX_DATA && reg_bus.done) rx_byte <= reg_bus.rdata[7:0];
	end

endmodule

/* uart_console_top.sv */
// Top level of the UART console, key and LEDs in, AXI4-Lite master port out to the hard UART
module uart_console_top (
	input  logic                         pll_0_clock,
	input  logic                         master_reset,
	input  logic                         key_n,
	output uart_console_pkg::led_t       led,
	output uart_console_pkg::axi_addr_t  awaddr,
	output logic [2:0]                   awprot,
	output logic                         awvalid,
	input  logic                         awready,
	output uart_console_pkg::axi_data_t  wdata,
	output logic [3:0]                   wstrb,
	output logic                         wvalid,
	input  logic                         wready,
	input  logic [1:0]                   bresp,
	input  logic                         bvalid,
	output logic                         bready,
	output uart_console_pkg::axi_addr_t  araddr,
	output logic [2:0]                   arprot,
	output logic                         arvalid,
	input  logic                         arready,
	input  uart_console_pkg::axi_data_t  rdata,
	input  logic [1:0]                   rresp,
	input  logic                         rvalid,
	output logic                         rready
);

	// Clean key level
	logic pressed;

	// Controller to master access channel
	uart_reg_if reg_bus ();

	// --------------------------------------------------
	// Key, console FSM, bus master
	// --------------------------------------------------

	key_debounce debounce_inst (
		.pll_0_clock  (pll_0_clock),
		.master_reset (master_reset),
		.key_n        (key_n),
		.pressed      (pressed)
	);

	uart_console_ctrl ctrl_inst (
		.pll_0_clock  (pll_0_clock),
		.master_reset (master_reset),
		.pressed      (pressed),
		.reg_bus      (reg_bus.ctrl),
		.led          (led)
	);

	axi_lite_master axi_master_inst (
		.pll_0_clock  (pll_0_clock),
		.master_reset (master_reset),
		.reg_bus      (reg_bus.master),
		.awaddr       (awaddr),
		.awprot       (awprot),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arprot       (arprot),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready)
	);

endmodule

/* uart_console_sva.sv */
// AXI4-Lite protocol checks, bound into every axi_lite_master instance
module axi_lite_sva (
	input logic                        pll_0_clock,
	input logic                        master_reset,
	input logic                        awvalid,
	input logic                        awready,
	input logic                        wvalid,
	input logic                        wready,
	input logic                        bvalid,
	input logic                        bready,
	input logic                        arvalid,
	input logic                        arready,
	input logic                        rvalid,
	input logic                        rready,
	input uart_console_pkg::axi_addr_t awaddr,
	input uart_console_pkg::axi_addr_t araddr,
	input uart_console_pkg::axi_data_t wdata
);

	// Count of failed assertions
	int failures = 0;
	// A transaction went out and its B or R handshake is still missing
	logic busy;

	always_ff @(posedge pll_0_clock or posedge master_reset) begin
		if (master_reset) begin
			busy <= 1'b0;
		end else if ((bvalid && bready) || (rvalid && rready)) begin
			busy <= 1'b0;
		end else if (awvalid || arvalid) begin
			busy <= 1'b1;
		end
	end

	// --------------------------------------------------
	// Valid held with a stable payload until ready
	// --------------------------------------------------

	aw_hold: assert property (@(posedge pll_0_clock) disable iff (master_reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			$error("awvalid dropped or awaddr changed before awready");
			failures++;
		end

	w_hold: assert property (@(posedge pll_0_clock) disable iff (master_reset)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			$error("wvalid dropped or wdata changed before wready");
			failures++;
		end

	ar_hold: assert property (@(posedge pll_0_clock) disable iff (master_reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("arvalid dropped or araddr changed before arready");
			failures++;
		end

	// One access in flight
	single_access: assert property (@(posedge pll_0_clock) disable iff (master_reset)
		!((awvalid || wvalid || bready) && (arvalid || rready)))
		else begin
			$error("read and write transactions overlap");
			failures++;
		end

	// New request only once the previous response has been taken
	no_early_request: assert property (@(posedge pll_0_clock) disable iff (master_reset)
		$rose(awvalid) || $rose(arvalid) |-> !busy)
		else begin
			$error("request issued before the previous access finished");
			failures++;
		end

	// Valids low on the first edge out of reset
	reset_idle: assert property (@(posedge pll_0_clock)
		$fell(master_reset) |-> !awvalid && !wvalid && !arvalid)
		else begin
			$error("valid signals high right after reset");
			failures++;
		end

endmodule

bind axi_lite_master axi_lite_sva sva0 (
	.pll_0_clock  (pll_0_clock),
	.master_reset (master_reset),
	.awvalid      (awvalid),
	.awready      (awready),
	.wvalid       (wvalid),
	.wready       (wready),
	.bvalid       (bvalid),
	.bready       (bready),
	.arvalid      (arvalid),
	.arready      (arready),
	.rvalid       (rvalid),
	.rready       (rready),
	.awaddr       (awaddr),
	.araddr       (araddr),
	.wdata        (wdata)
);

/* tb_uart_console.sv */
// Testbench for the UART console top, with an AXI4-Lite UART register model and LCG back-pressure
module tb_uart_console;

	// --------------------------------------------------
	// Run length and limits
	// --------------------------------------------------

	localparam int NUM_DIGITS = 12;
	localparam int NUM_OTHERS = 6;
	// Worst single access is four channels at 3 cycles each plus FSM overhead
	localparam int MAX_ACCESS_CYCLES = 24;
	localparam int TOTAL_BYTES = uart_console_pkg::HELLO_MSG_LEN + 2 * (NUM_DIGITS + NUM_OTHERS);
	localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 4 * MAX_ACCESS_CYCLES * 2
		+ (NUM_DIGITS + NUM_OTHERS + 4) * uart_console_pkg::POLL_CYCLES * 2
		+ 4 * uart_console_pkg::DEBOUNCE_CYCLES + 2000;

	logic pll_0_clock;
	logic master_reset;
	logic key_n;
	uart_console_pkg::led_t led;
	uart_console_pkg::axi_addr_t awaddr;
	uart_console_pkg::axi_addr_t araddr;
	uart_console_pkg::axi_data_t wdata;
	uart_console_pkg::axi_data_t rdata;
	logic [2:0] awprot;
	logic [2:0] arprot;
	logic [3:0] wstrb;
	logic [1:0] bresp;
	logic [1:0] rresp;
	logic awvalid;
	logic awready;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic arvalid;
	logic arready;
	logic rvalid;
	logic rready;

	// Model state
	uart_console_pkg::uart_byte_t rx_q[$];
	uart_console_pkg::uart_byte_t tx_q[$];
	int unsigned seed = 33;
	int errors = 0;
	int tests_failed = 0;
	int cycles = 0;
	int aw_dly = 0;
	int w_dly = 0;
	int b_dly = 0;
	int ar_dly = 0;
	int r_dly = 0;
	logic got_aw = 1'b0;
	logic got_w = 1'b0;
	logic got_ar = 1'b0;
	// Set when the last LSR read showed THRE and cleared by a write
	logic thre_armed = 1'b0;
	uart_console_pkg::axi_addr_t wr_addr;
	uart_console_pkg::uart_byte_t wr_byte;
	uart_console_pkg::axi_data_t rd_word;
	// Handshakes seen mid-cycle complete on the next rising edge
	logic aw_hs;
	logic w_hs;
	logic b_hs;
	logic ar_hs;
	logic r_hs;
	uart_console_pkg::axi_addr_t cap_awaddr;
	uart_console_pkg::axi_addr_t cap_araddr;
	uart_console_pkg::axi_data_t cap_wdata;

	uart_console_top dut0 (.*);

	always #20 pll_0_clock = ~pll_0_clock;

	// --------------------------------------------------
	// Random numbers and reference
	// --------------------------------------------------

	function int unsigned lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed >> 16;
	endfunction

	// Response delay of 0 to 3 cycles
	function int rand_delay();
		return int'(lcg_next() % 4);
	endfunction

	// Expected LED bank after one received byte
	// Digits '0' to '7' flip one bit
	function uart_console_pkg::led_t expected_led(uart_console_pkg::led_t cur,
			uart_console_pkg::uart_byte_t b);
		if (b >= "0" && b <= "7") return cur ^ (uart_console_pkg::led_t'(1) << (b - 8'h30));
		return cur;
	endfunction

	// --------------------------------------------------
	// UART register model
	// --------------------------------------------------

	task automatic apply_read(input uart_console_pkg::axi_addr_t addr,
			output uart_console_pkg::axi_data_t word);
		logic thre;
		word = '0;
		if (addr == uart_console_pkg::UART_BASE_ADDR + uart_console_pkg::UART_LSR_OFFSET) begin
			// THRE set three times out of four
			thre = (lcg_next() % 4) != 0;
			thre_armed = thre;
			word[uart_console_pkg::LSR_THRE_BIT] = thre;
			word[uart_console_pkg::LSR_DR_BIT] = rx_q.size() != 0;
		end else if (addr == uart_console_pkg::UART_BASE_ADDR) begin
			assert (rx_q.size() != 0) else begin
				$display("RBR was read while the receive queue was empty");
				errors++;
			end
			if (rx_q.size() != 0) word[7:0] = rx_q.pop_front();
		end else begin
			$display("FAIL araddr got 0x%08h, not a UART register", addr);
			errors++;
		end
	endtask

	task automatic apply_write();
		assert (wr_addr == uart_console_pkg::UART_BASE_ADDR + uart_console_pkg::UART_RBR_THR_OFFSET)
		else begin
			$display("FAIL awaddr got 0x%08h expected 0x%08h", wr_addr,
				uart_console_pkg::UART_BASE_ADDR);
			errors++;
		end
		assert (thre_armed) else begin
			$display("THR was written without a preceding LSR read showing THRE");
			errors++;
		end
		thre_armed = 1'b0;
		tx_q.push_back(wr_byte);
	endtask

	always @(negedge pll_0_clock) begin
		aw_hs = awvalid && awready;
		w_hs = wvalid && wready;
		b_hs = bvalid && bready;
		ar_hs = arvalid && arready;
		r_hs = rvalid && rready;
		cap_awaddr = awaddr;
		cap_araddr = araddr;
		cap_wdata = wdata;
		// Protection and strobes are fixed for every console access
		if (aw_hs) begin
			assert (awprot == 3'b000) else begin
				$display("FAIL awprot got 0x%0h expected 0x0", awprot);
				errors++;
			end
		end
		if (w_hs) begin
			assert (wstrb == 4'b0001) else begin
				$display("FAIL wstrb got 0x%0h expected 0x1", wstrb);
				errors++;
			end
		end
		if (ar_hs) begin
			assert (arprot == 3'b000) else begin
				$display("FAIL arprot got 0x%0h expected 0x0", arprot);
				errors++;
			end
		end
	end

	// Responses change a fixed delay after the edge
	always @(posedge pll_0_clock) begin
		#2;
		if (!master_reset) begin
			// Write address and data each with its own delay
			if (aw_hs) begin
				awready = 1'b0;
				got_aw = 1'b1;
				wr_addr = cap_awaddr;
				aw_dly = rand_delay();
			end else if (awvalid && !awready) begin
				if (aw_dly == 0) awready = 1'b1;
				else aw_dly--;
			end
			if (w_hs) begin
				wready = 1'b0;
				got_w = 1'b1;
				wr_byte = cap_wdata[7:0];
				w_dly = rand_delay();
			end else if (wvalid && !wready) begin
				if (w_dly == 0) wready = 1'b1;
				else w_dly--;
			end
			// Write response once both halves are in
			if (b_hs) begin
				bvalid = 1'b0;
			end else if (got_aw && got_w && !bvalid) begin
				if (b_dly == 0) begin
					apply_write();
					got_aw = 1'b0;
					got_w = 1'b0;
					bvalid = 1'b1;
					b_dly = rand_delay();
				end else begin
					b_dly--;
				end
			end
			// Register read takes effect on the read address handshake
			if (ar_hs) begin
				arready = 1'b0;
				got_ar = 1'b1;
				apply_read(cap_araddr, rd_word);
				ar_dly = rand_delay();
			end else if (arvalid && !arready) begin
				if (ar_dly == 0) arready = 1'b1;
				else ar_dly--;
			end
			if (r_hs) begin
				rvalid = 1'b0;
			end else if (got_ar && !rvalid) begin
				if (r_dly == 0) begin
					rdata = rd_word;
					rvalid = 1'b1;
					got_ar = 1'b0;
					r_dly = rand_delay();
				end else begin
					r_dly--;
				end
			end
		end
	end

	// --------------------------------------------------
	// Timeout
	// --------------------------------------------------

	always @(posedge pll_0_clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: failed", name);
			tests_failed++;
		end
	endtask

	task automatic wait_tx(input int n);
		while (tx_q.size() < n) @(posedge pll_0_clock);
	endtask

	// Push one byte into the receiver and check echo and LEDs
	task automatic receive_byte(input uart_console_pkg::uart_byte_t b,
			inout uart_console_pkg::led_t led_exp);
		uart_console_pkg::uart_byte_t echo;
		rx_q.push_back(b);
		led_exp = expected_led(led_exp, b);
		wait_tx(1);
		echo = tx_q.pop_front();
		assert (echo == b) else begin
			$display("FAIL wdata[7:0] got 0x%02h expected 0x%02h", echo, b);
			errors++;
		end
		assert (led == led_exp) else begin
			$display("FAIL led got 0x%02h expected 0x%02h", led, led_exp);
			errors++;
		end
	endtask

	initial begin
		string greeting;
		uart_console_pkg::led_t led_exp;
		uart_console_pkg::uart_byte_t others[NUM_OTHERS];
		int start;
		greeting = "Hello from the FPGA side\r\n";
		others = '{8'h41, 8'h2f, 8'h38, 8'h39, 8'h00, 8'hff};
		pll_0_clock = 1'b0;
		master_reset = 1'b1;
		key_n = 1'b1;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = uart_console_pkg::AXI_RESP_OKAY;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = uart_console_pkg::AXI_RESP_OKAY;
		repeat (2) @(posedge pll_0_clock);
		#2 master_reset = 1'b0;

		// Reset values before any stimulus
		start = errors;
		assert (led == '0 && !awvalid && !wvalid && !arvalid) else begin
			$display("FAIL led 0x%02h awvalid %0h wvalid %0h arvalid %0h after reset",
				led, awvalid, wvalid, arvalid);
			errors++;
		end
		report_test("reset", start);

		// Greeting after a press and release
		start = errors;
		@(posedge pll_0_clock);
		#2 key_n = 1'b0;
		repeat (uart_console_pkg::DEBOUNCE_CYCLES + 10) @(posedge pll_0_clock);
		#2 key_n = 1'b1;
		wait_tx(uart_console_pkg::HELLO_MSG_LEN);
		// Let a few polls pass to catch stray writes
		repeat (3 * uart_console_pkg::POLL_CYCLES) @(posedge pll_0_clock);
		assert (tx_q.size() == uart_console_pkg::HELLO_MSG_LEN) else begin
			$display("Greeting wrote %0d bytes instead of %0d", tx_q.size(),
				uart_console_pkg::HELLO_MSG_LEN);
			errors++;
		end
		for (int i = 0; i < uart_console_pkg::HELLO_MSG_LEN && i < tx_q.size(); i++) begin
			assert (tx_q[i] == greeting[i]) else begin
				$display("FAIL wdata[7:0] byte %0d got 0x%02h expected 0x%02h",
					i, tx_q[i], greeting[i]);
				errors++;
			end
		end
		tx_q.delete();
		report_test("greeting", start);

		// Digits in random order with repeats
		start = errors;
		led_exp = '0;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			receive_byte(uart_console_pkg::DIGIT_BASE + uart_console_pkg::uart_byte_t'(lcg_next() % 8),
				led_exp);
		end
		report_test("digits", start);

		// Other bytes only echo
		start = errors;
		for (int i = 0; i < NUM_OTHERS; i++) receive_byte(others[i], led_exp);
		report_test("non-digits", start);

		// Protocol checker results over the whole run
		start = errors;
		errors += dut0.axi_master_inst.sva0.failures;
		report_test("protocol", start);

		$display("Tests run: 5, tests failed: %0d, checks failed: %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* filelist.f */
uart_console_pkg.sv
uart_reg_if.sv
key_debounce.sv
axi_lite_master.sv
uart_console_ctrl.sv
uart_console_top.sv
uart_console_sva.sv
tb_uart_console.sv

/* run.sh */
#!/bin/sh
# Build and run the UART console simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_uart_console

output=$(./obj_dir/Vtb_uart_console)
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
	exit 0
else
	exit 1
fi
